// File: verilog/led_pkg.sv
package led_pkg;

	localparam int NUM_LEDS = 8;

	typedef logic [3:0]            led_mode_t;
	typedef logic [4*NUM_LEDS-1:0] led_word_t;  // led n in bits 4n+3:4n
	typedef logic [NUM_LEDS-1:0]   led_vec_t;

	localparam led_mode_t LED_OFF    = 4'd0;
	localparam led_mode_t LED_ON     = 4'd1;
	localparam led_mode_t LED_SPARK  = 4'd2;  // one shot
	localparam led_mode_t LED_SPARK1 = 4'd3;  // free running blink
	localparam led_mode_t LED_BLING  = 4'd4;  // blink paced by step pulses
	// 5..7 leave the shown bit alone

	// set on led 1 only: follow api_idle
	localparam int LED_API_BIT = 3;

	typedef enum logic [1:0] {
		SH_IDLE,
		SH_LOW,
		SH_HIGH,
		SH_LATCH
	} shift_state_t;

endpackage

// File: verilog/led_channel.sv
`timescale 1ns/10ps

module led_channel #(
	parameter int CNT_W     = 25,
	parameter int SPARK_MAX = 15000000,
	parameter int BLING_MAX = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               mode_wr,
	input  led_pkg::led_mode_t mode,
	input  logic               step,
	output logic               led,
	output logic               toggle
);

	led_pkg::led_mode_t mode_q;  // last written code
	logic [CNT_W-1:0]   cnt;
	logic               blink_code;
	logic               wr_start;
	logic               wr_clear;
	logic               cnt_hit;

	assign blink_code = (mode == led_pkg::LED_SPARK1) || (mode == led_pkg::LED_BLING);

	// rewriting the same blink code keeps the running phase
	assign wr_start = mode_wr &&
		((mode == led_pkg::LED_SPARK) || (blink_code && (mode != mode_q)));
	assign wr_clear = mode_wr && !blink_code && (mode != led_pkg::LED_SPARK);

	assign cnt_hit = (mode_q == led_pkg::LED_BLING) ? (cnt == CNT_W'(BLING_MAX)) :
		(cnt == CNT_W'(SPARK_MAX));

	// a fresh start or a static code overrides the phase end
	assign toggle = cnt_hit && !wr_start && !wr_clear;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode_q <= led_pkg::LED_OFF;
		end else if (mode_wr) begin
			mode_q <= mode;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (wr_clear) begin
			cnt <= '0;
		end else if (wr_start) begin
			cnt <= CNT_W'(1);
		end else if (cnt_hit) begin
			// spark parks at 0, blink modes reload
			cnt <= (mode_q == led_pkg::LED_SPARK) ? '0 : CNT_W'(1);
		end else if (cnt != '0) begin
			if (mode_q == led_pkg::LED_BLING) begin
				cnt <= cnt + CNT_W'(step);  // only on activity
			end else begin
				cnt <= cnt + CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			led <= 1'b0;
		end else if (mode_wr && (mode == led_pkg::LED_OFF)) begin
			led <= 1'b0;
		end else if (mode_wr && ((mode == led_pkg::LED_ON) || (mode == led_pkg::LED_SPARK))) begin
			led <= 1'b1;
		end else if (toggle) begin
			led <= ~led;
		end
	end

	// phase counter stays within its range for every mode sequence
	a_cnt_bound: assert property (
		@(posedge clk) disable iff (rst)
		cnt <= CNT_W'(SPARK_MAX)
	);

endmodule

// File: verilog/led_ctrl.sv
`timescale 1ns/10ps

module led_ctrl #(
	parameter int CNT_W     = 25,
	parameter int SPARK_MAX = 15000000,
	parameter int BLING_MAX = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               mode_wr,
	input  led_pkg::led_word_t mode_word,
	input  led_pkg::led_vec_t  bling_step,
	input  logic               api_idle,
	output led_pkg::led_vec_t  leds,
	output logic               frame_req
);

	led_pkg::led_vec_t chan_led;
	led_pkg::led_vec_t chan_tog;
	led_pkg::led_vec_t shown_tog;  // toggles that reach the panel
	logic              api_q1;
	logic              api_q2;
	logic              api_en;
	logic              api_chg;

	genvar i;
	generate
		for (i = 0; i < led_pkg::NUM_LEDS; i++) begin : g_chan
			led_pkg::led_mode_t chan_mode;

			// bit 3 is not a channel mode bit
			assign chan_mode = {1'b0, mode_word[4*i +: 3]};

			led_channel #(
				.CNT_W     (CNT_W),
				.SPARK_MAX (SPARK_MAX),
				.BLING_MAX (BLING_MAX)
			) i_led_channel (
				.clk     (clk),
				.rst     (rst),
				.mode_wr (mode_wr),
				.mode    (chan_mode),
				.step    (bling_step[i]),
				.led     (chan_led[i]),
				.toggle  (chan_tog[i])
			);
		end
	endgenerate

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			api_q1 <= 1'b0;
			api_q2 <= 1'b0;
		end else begin
			api_q1 <= api_idle;
			api_q2 <= api_q1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			api_en <= 1'b0;
		end else if (mode_wr) begin
			api_en <= mode_word[4 + led_pkg::LED_API_BIT];
		end
	end

	// shown bit 1 moves on the next edge
	assign api_chg = api_en && (api_q1 != api_q2);

	always_comb begin
		leds      = chan_led;
		shown_tog = chan_tog;
		if (api_en) begin
			leds[1]      = api_q2;
			shown_tog[1] = 1'b0;  // hidden behind api follow
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_req <= 1'b0;
		end else begin
			frame_req <= mode_wr || (|shown_tog) || api_chg;
		end
	end

	// no change of the shown pattern goes out without a frame request
	a_change_req: assert property (
		@(posedge clk) disable iff (rst)
		(leds != $past(leds)) |-> frame_req
	);

endmodule

// File: verilog/led_shift.sv
`timescale 1ns/10ps

module led_shift (
	input  logic              clk,
	input  logic              rst,
	input  logic              frame_req,
	input  led_pkg::led_vec_t leds,
	output logic              sft_ds,
	output logic              sft_shcp,
	output logic              sft_stcp
);

	led_pkg::shift_state_t state;
	led_pkg::led_vec_t     pat;  // frame being sent
	logic [2:0]            idx;
	logic                  pending;
	logic                  start;

	// back to back frames restart straight from the latch cycle
	assign start = ((state == led_pkg::SH_IDLE) && frame_req) ||
		((state == led_pkg::SH_LATCH) && (pending || frame_req));

	always_ff @(posedge clk) begin
		if (start) begin
			pat <= leds;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= led_pkg::SH_IDLE;
			idx      <= 3'd7;
			pending  <= 1'b0;
			sft_ds   <= 1'b0;
			sft_shcp <= 1'b0;
			sft_stcp <= 1'b0;
		end else begin
			if (start) begin
				pending <= 1'b0;
			end else if (frame_req) begin
				pending <= 1'b1;  // merged into one later frame
			end
			if (start) begin
				state    <= led_pkg::SH_LOW;
				idx      <= 3'd7;
				sft_ds   <= leds[7];  // msb first
				sft_stcp <= 1'b0;
			end else begin
				case (state)
					led_pkg::SH_LOW: begin
						sft_shcp <= 1'b1;
						state    <= led_pkg::SH_HIGH;
					end
					led_pkg::SH_HIGH: begin
						sft_shcp <= 1'b0;
						if (idx == 3'd0) begin
							sft_stcp <= 1'b1;
							state    <= led_pkg::SH_LATCH;
						end else begin
							idx    <= idx - 3'd1;
							sft_ds <= pat[idx - 3'd1];
							state  <= led_pkg::SH_LOW;
						end
					end
					led_pkg::SH_LATCH: begin
						sft_stcp <= 1'b0;
						state    <= led_pkg::SH_IDLE;
					end
					default: state <= led_pkg::SH_IDLE;
				endcase
			end
		end
	end

	a_clk_latch: assert property (
		@(posedge clk) disable iff (rst)
		!(sft_stcp && sft_shcp)
	);

endmodule

// File: verilog/led_panel_top.sv
`timescale 1ns/10ps

module led_panel_top #(
	parameter int CNT_W     = 25,
	parameter int SPARK_MAX = 15000000,
	parameter int BLING_MAX = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               mode_wr,
	input  led_pkg::led_word_t mode_word,
	input  led_pkg::led_vec_t  bling_step,
	input  logic               api_idle,
	output logic               sft_ds,
	output logic               sft_shcp,
	output logic               sft_stcp
);

	led_pkg::led_vec_t leds;
	logic              frame_req;

	led_ctrl #(
		.CNT_W     (CNT_W),
		.SPARK_MAX (SPARK_MAX),
		.BLING_MAX (BLING_MAX)
	) i_led_ctrl (
		.clk        (clk),
		.rst        (rst),
		.mode_wr    (mode_wr),
		.mode_word  (mode_word),
		.bling_step (bling_step),
		.api_idle   (api_idle),
		.leds       (leds),
		.frame_req  (frame_req)
	);

	led_shift i_led_shift (
		.clk       (clk),
		.rst       (rst),
		.frame_req (frame_req),
		.leds      (leds),
		.sft_ds    (sft_ds),
		.sft_shcp  (sft_shcp),
		.sft_stcp  (sft_stcp)
	);

endmodule

// File: testbench/led_panel_checker.sv
`timescale 1ns/10ps

module led_panel_checker (
	input  logic              clk,
	input  logic              rst,
	input  logic              sft_ds,
	input  logic              sft_shcp,
	input  logic              sft_stcp,
	input  logic              chk_en,
	input  led_pkg::led_vec_t exp_frame,
	input  led_pkg::led_vec_t exp_mask,
	output int                frame_cnt,
	output led_pkg::led_vec_t last_frame,
	output int                chk_cnt,
	output int                err_cnt
);

	led_pkg::led_vec_t shreg;  // shift stage of the external part
	logic              shcp_q;

	// rising shift clock seen against clk
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shreg  <= '0;
			shcp_q <= 1'b0;
		end else begin
			shcp_q <= sft_shcp;
			if (sft_shcp && !shcp_q) begin
				shreg <= {shreg[6:0], sft_ds};
			end
		end
	end

	// storage stage of the external part
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_cnt  <= 0;
			last_frame <= '0;
		end else if (sft_stcp) begin
			frame_cnt  <= frame_cnt + 1;
			last_frame <= shreg;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			chk_cnt <= 0;
			err_cnt <= 0;
		end else if (chk_en) begin
			chk_cnt <= chk_cnt + 1;
			if ((last_frame & exp_mask) != (exp_frame & exp_mask)) begin
				err_cnt <= err_cnt + 1;
				$display("mismatch at %0t ns: leds expected %b got %b (mask %b)", $time,
					exp_frame & exp_mask, last_frame & exp_mask, exp_mask);
			end
		end
	end

endmodule

// File: testbench/tb_led_panel.sv
`timescale 1ns/10ps

module tb_led_panel;

	localparam int CNT_W      = 8;
	localparam int SPARK_MAX  = 40;
	localparam int BLING_MAX  = 4;
	localparam int IDLE       = 40;  // settle time after a change
	localparam int FRAME_WAIT = 60;
	localparam int NUM_WORDS  = 10;
	localparam int PHASES     = 6;
	localparam int BLING_LED  = 4;
	localparam led_pkg::led_vec_t BLINK_MASK = 8'h04;  // led 2
	localparam led_pkg::led_vec_t BLING_MASK = 8'h10;

	localparam int T_QUIET  = 16 + 24 + 2;
	localparam int T_STEADY = NUM_WORDS * (IDLE + 6);
	localparam int T_SPARK  = FRAME_WAIT + SPARK_MAX + IDLE + 10;
	localparam int T_SPARK1 = IDLE + 2 * FRAME_WAIT + PHASES * (SPARK_MAX + 32) + 16;
	localparam int T_BLING  = 3 * IDLE + 110 + 2 * BLING_MAX + 10;
	localparam int T_API    = 3 * FRAME_WAIT + IDLE + 14;
	localparam int CYCLE_LIMIT =
		T_QUIET + T_STEADY + T_SPARK + T_SPARK1 + T_BLING + T_API + 200;

	logic               clk;
	logic               rst;
	logic               mode_wr;
	led_pkg::led_word_t mode_word;
	led_pkg::led_vec_t  bling_step;
	logic               api_idle;
	logic               sft_ds;
	logic               sft_shcp;
	logic               sft_stcp;
	logic               chk_en;
	led_pkg::led_vec_t  exp_frame;
	led_pkg::led_vec_t  exp_mask;
	int                 frame_cnt;
	led_pkg::led_vec_t  last_frame;
	int                 chk_cnt;
	int                 err_cnt;
	int                 tb_errs;
	int                 errs_before;
	int                 cycle = 0;
	logic [15:0]        lfsr_state;

	led_panel_top #(
		.CNT_W     (CNT_W),
		.SPARK_MAX (SPARK_MAX),
		.BLING_MAX (BLING_MAX)
	) i_led_panel_top (
		.clk        (clk),
		.rst        (rst),
		.mode_wr    (mode_wr),
		.mode_word  (mode_word),
		.bling_step (bling_step),
		.api_idle   (api_idle),
		.sft_ds     (sft_ds),
		.sft_shcp   (sft_shcp),
		.sft_stcp   (sft_stcp)
	);

	led_panel_checker i_led_panel_checker (
		.clk        (clk),
		.rst        (rst),
		.sft_ds     (sft_ds),
		.sft_shcp   (sft_shcp),
		.sft_stcp   (sft_stcp),
		.chk_en     (chk_en),
		.exp_frame  (exp_frame),
		.exp_mask   (exp_mask),
		.frame_cnt  (frame_cnt),
		.last_frame (last_frame),
		.chk_cnt    (chk_cnt),
		.err_cnt    (err_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cycle);
			$display("Done: errors found");
			$finish;
		end
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	// settled pattern, blink codes have none and give 0
	function automatic led_pkg::led_vec_t expected_leds(input led_pkg::led_word_t w,
		input logic api);
		led_pkg::led_vec_t  v;
		led_pkg::led_mode_t code;
		logic               api_on;
		for (int n = 0; n < led_pkg::NUM_LEDS; n++) begin
			code   = w[4*n +: 4];
			api_on = (n == 1) && code[led_pkg::LED_API_BIT];
			code[led_pkg::LED_API_BIT] = 1'b0;
			v[n]   = api_on ? api : (code == led_pkg::LED_ON);  // spark ends dark
		end
		return v;
	endfunction

	function automatic led_pkg::led_vec_t spark_leds(input led_pkg::led_word_t w);
		led_pkg::led_vec_t v;
		for (int n = 0; n < led_pkg::NUM_LEDS; n++) begin
			v[n] = (w[4*n +: 4] == led_pkg::LED_SPARK);
		end
		return v;
	endfunction

	task automatic write_word(input led_pkg::led_word_t w);
		@(posedge clk);
		mode_word <= w;
		mode_wr   <= 1'b1;
		@(posedge clk);
		mode_wr   <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_frame(input int max_cycles, output int waited);
		int start;
		start  = frame_cnt;
		waited = 0;
		while (frame_cnt == start && waited < max_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (frame_cnt == start) begin
			tb_errs++;
			$display("no frame arrived within %0d cycles at %0t ns", max_cycles, $time);
		end
	endtask

	task automatic check_frame(input led_pkg::led_vec_t exp, input led_pkg::led_vec_t mask);
		@(posedge clk);
		exp_frame <= exp;
		exp_mask  <= mask;
		chk_en    <= 1'b1;
		@(posedge clk);
		chk_en    <= 1'b0;
	endtask

	task automatic check_quiet();
		if (sft_ds || sft_shcp || sft_stcp) begin
			tb_errs++;
			$display("serial outputs active before the first write at %0t ns", $time);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		@(negedge clk);
		errs = err_cnt + tb_errs - errs_before;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errs);
		end
		errs_before = err_cnt + tb_errs;
	endtask

	initial begin
		logic               b;
		led_pkg::led_word_t w;
		logic               prev;
		int                 waited;
		int                 t_last;
		int                 start_cnt;
		int                 total;
		rst         = 1'b1;
		mode_wr     = 1'b0;
		mode_word   = '0;
		bling_step  = '0;
		api_idle    = 1'b0;
		chk_en      = 1'b0;
		exp_frame   = '0;
		exp_mask    = '0;
		tb_errs     = 0;
		errs_before = 0;
		lfsr_state  = 16'd45253;

		for (int c = 0; c < 16; c++) begin
			@(posedge clk);
			if (c > 1) begin
				check_quiet();
			end
		end
		rst <= 1'b0;
		repeat (24) begin
			@(posedge clk);
			check_quiet();
		end
		if (frame_cnt != 0) begin
			tb_errs++;
			$display("a frame was latched before the first write");
		end
		end_test("reset quiet");

		for (int k = 0; k < NUM_WORDS; k++) begin
			for (int n = 0; n < led_pkg::NUM_LEDS; n++) begin
				take_bit(b);
				w[4*n +: 4] = b ? led_pkg::LED_ON : led_pkg::LED_OFF;
			end
			write_word(w);
			idle(IDLE);
			check_frame(expected_leds(w, api_idle), '1);
		end
		end_test("steady modes");

		for (int n = 0; n < led_pkg::NUM_LEDS; n++) begin
			take_bit(b);
			w[4*n +: 4] = (b || n == 0) ? led_pkg::LED_SPARK : led_pkg::LED_OFF;
		end
		write_word(w);
		wait_frame(FRAME_WAIT, waited);
		check_frame(expected_leds(w, api_idle) | spark_leds(w), '1);
		idle(SPARK_MAX + IDLE - waited);
		check_frame(expected_leds(w, api_idle), '1);
		end_test("spark");

		write_word('0);
		idle(IDLE);
		w = '0;
		w[8 +: 4] = led_pkg::LED_SPARK1;
		write_word(w);
		wait_frame(FRAME_WAIT, waited);
		prev = 1'b0;  // off left it dark
		check_frame('0, BLINK_MASK);
		t_last = cycle;
		for (int p = 1; p <= PHASES; p++) begin
			wait_frame(SPARK_MAX + 30, waited);
			prev = ~prev;
			if (p > 1 && cycle - t_last > SPARK_MAX + 10) begin
				tb_errs++;
				$display("blink phase %0d took %0d cycles, the blink restarted", p,
					cycle - t_last);
			end
			t_last = cycle;
			check_frame(prev ? BLINK_MASK : '0, BLINK_MASK);
			if (p == 3) begin
				write_word(w);  // same code, phase runs on
				wait_frame(FRAME_WAIT, waited);
				check_frame(prev ? BLINK_MASK : '0, BLINK_MASK);
			end
		end
		write_word('0);
		end_test("spark1");

		w = '0;
		w[4*BLING_LED +: 4] = led_pkg::LED_ON;
		write_word(w);
		idle(IDLE);
		w[4*BLING_LED +: 4] = led_pkg::LED_BLING;
		start_cnt = frame_cnt;
		write_word(w);
		idle(100);
		if (frame_cnt != start_cnt + 1) begin
			tb_errs++;
			$display("bling sent %0d frames with no step pulse, expected 1",
				frame_cnt - start_cnt);
		end
		check_frame(BLING_MASK, BLING_MASK);
		for (int k = 1; k < BLING_MAX; k++) begin
			@(posedge clk);
			bling_step <= BLING_MASK;
			@(posedge clk);
			bling_step <= '0;
			if (k == BLING_MAX - 2) begin
				idle(IDLE);
				check_frame(BLING_MASK, BLING_MASK);  // one pulse short
			end
		end
		idle(IDLE);
		check_frame('0, BLING_MASK);
		end_test("bling");

		w = '0;
		w[4 + led_pkg::LED_API_BIT] = 1'b1;
		write_word(w);
		wait_frame(FRAME_WAIT, waited);
		check_frame(expected_leds(w, api_idle), '1);
		idle(IDLE);
		for (int k = 0; k < 2; k++) begin
			@(posedge clk);
			api_idle <= ~api_idle;
			wait_frame(FRAME_WAIT, waited);
			check_frame(expected_leds(w, api_idle), '1);
		end
		end_test("api follow");

		total = err_cnt + tb_errs;
		$display("checks: %0d, frames: %0d, errors: %0d", chk_cnt, frame_cnt, total);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: flist.f
verilog/led_pkg.sv
verilog/led_channel.sv
verilog/led_ctrl.sv
verilog/led_shift.sv
verilog/led_panel_top.sv
testbench/led_panel_checker.sv
testbench/tb_led_panel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the led panel testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f flist.f --top-module tb_led_panel -Mdir obj_dir -o tb_led_panel
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_led_panel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
	exit 0
fi
echo "simulation reported failures"
exit 1
